//--- src/egress_pkg.sv
// Egress queueing shared definitions
// Widths, counts, stream beat and descriptor layouts, memory request
// formats and the round-robin helpers used by every arbiter
`default_nettype none

package egress_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int NUM_PORTS    = 2;
    localparam int DATA_WID     = 64;
    localparam int BUFFER_BEATS = 8;
    localparam int NUM_BUFFERS  = 16;
    localparam int DESC_DEPTH   = 8;
    localparam int PORT_WID     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int BUF_PTR_WID  = $clog2(NUM_BUFFERS);
    localparam int BEAT_IDX_WID = $clog2(BUFFER_BEATS);
    localparam int DESC_PTR_WID = $clog2(DESC_DEPTH);

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [PORT_WID-1:0]     port_t;
    typedef logic [DATA_WID-1:0]     data_t;
    typedef logic [BUF_PTR_WID-1:0]  buf_ptr_t;
    typedef logic [BEAT_IDX_WID-1:0] beat_idx_t;
    // Holds 1 to BUFFER_BEATS
    typedef logic [BEAT_IDX_WID:0]   pkt_len_t;

    typedef struct packed {
        data_t data;
        logic  last;
        port_t dest;
    } beat_t;

    typedef struct packed {
        buf_ptr_t ptr;
        pkt_len_t len;
        port_t    dest;
    } desc_t;

    typedef struct packed {
        buf_ptr_t  ptr;
        beat_idx_t idx;
    } mem_addr_t;

    typedef struct packed {
        mem_addr_t addr;
        data_t     data;
    } mem_wr_t;

    // One-hot pick of the first requester after the last one served
    function automatic logic [NUM_PORTS-1:0] rr_pick(input logic [NUM_PORTS-1:0] req,
                                                     input port_t last);
        logic [NUM_PORTS-1:0] gnt;
        int idx;
        gnt = '0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = (int'(last) + k) % NUM_PORTS;
            if (gnt == '0 && req[idx]) begin
                gnt[idx] = 1'b1;
            end
        end
        return gnt;
    endfunction

    function automatic port_t oh_to_port(input logic [NUM_PORTS-1:0] oh);
        port_t idx;
        idx = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            if (oh[k]) begin
                idx = port_t'(k);
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

//--- src/egress_free_list.sv
// Buffer pointer free list
// Loads every buffer pointer once after reset, then hands out one
// pointer per cycle to the requesting ports in round-robin order and
// takes back all released pointers in the same cycle
`timescale 1ns/1ns
`default_nettype none

module egress_free_list (
    input  logic                                i_core_clk,
    input  logic                                i_rst,
    input  logic [egress_pkg::NUM_PORTS-1:0]    i_alloc_req,
    output logic [egress_pkg::NUM_PORTS-1:0]    o_alloc_gnt,
    output egress_pkg::buf_ptr_t                o_alloc_ptr,
    input  logic [egress_pkg::NUM_PORTS-1:0]    i_rel_valid,
    input  egress_pkg::buf_ptr_t                i_rel_ptr [egress_pkg::NUM_PORTS],
    output logic                                o_init_done
);
    import egress_pkg::*;

    typedef enum logic {INIT, RUN} fill_state_t;

    fill_state_t          state;
    buf_ptr_t             init_cnt;
    buf_ptr_t             fifo [NUM_BUFFERS];
    buf_ptr_t             wr_ptr;
    buf_ptr_t             rd_ptr;
    logic [BUF_PTR_WID:0] count;
    logic [BUF_PTR_WID:0] n_push;
    port_t                rr_last;
    logic                 pop;
    logic [NUM_PORTS-1:0] push_vld;
    buf_ptr_t             push_val  [NUM_PORTS];
    buf_ptr_t             push_slot [NUM_PORTS];

    assign o_init_done = (state == RUN);
    assign o_alloc_gnt = (state == RUN && count != '0) ? rr_pick(i_alloc_req, rr_last) : '0;
    assign o_alloc_ptr = fifo[rd_ptr];
    assign pop         = |o_alloc_gnt;

    // Pushes pack into consecutive slots after the write pointer
    always_comb begin
        n_push = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (state == INIT) begin
                push_vld[p] = (p == 0);
                push_val[p] = init_cnt;
            end else begin
                push_vld[p] = i_rel_valid[p];
                push_val[p] = i_rel_ptr[p];
            end
            push_slot[p] = wr_ptr + n_push[BUF_PTR_WID-1:0];
            if (push_vld[p]) begin
                n_push = n_push + 1'b1;
            end
        end
    end

    always_ff @(posedge i_core_clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (push_vld[p]) begin
                fifo[push_slot[p]] <= push_val[p];
            end
        end
    end

    always_ff @(posedge i_core_clk) begin
        if (i_rst) begin
            state    <= INIT;
            init_cnt <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rr_last  <= '0;
        end else begin
            wr_ptr <= wr_ptr + n_push[BUF_PTR_WID-1:0];
            count  <= count + n_push - {{BUF_PTR_WID{1'b0}}, pop};
            if (pop) begin
                rd_ptr  <= rd_ptr + 1'b1;
                rr_last <= oh_to_port(o_alloc_gnt);
            end
            if (state == INIT) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == buf_ptr_t'(NUM_BUFFERS - 1)) begin
                    state <= RUN;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/egress_pkt_mem.sv
// Shared packet buffer memory
// One write port and one read port, each arbitrated round-robin
// between the port queues. Read data returns one cycle after grant.
`timescale 1ns/1ns
`default_nettype none

module egress_pkt_mem (
    input  logic                                i_core_clk,
    input  logic                                i_rst,
    input  logic [egress_pkg::NUM_PORTS-1:0]    i_wr_req,
    input  egress_pkg::mem_wr_t                 i_wr [egress_pkg::NUM_PORTS],
    output logic [egress_pkg::NUM_PORTS-1:0]    o_wr_gnt,
    input  logic [egress_pkg::NUM_PORTS-1:0]    i_rd_req,
    input  egress_pkg::mem_addr_t               i_rd_addr [egress_pkg::NUM_PORTS],
    output logic [egress_pkg::NUM_PORTS-1:0]    o_rd_gnt,
    output logic [egress_pkg::NUM_PORTS-1:0]    o_rd_valid,
    output egress_pkg::data_t                   o_rd_data
);
    import egress_pkg::*;

    data_t ram [NUM_BUFFERS*BUFFER_BEATS];
    port_t wr_last;
    port_t rd_last;
    port_t wr_sel;
    port_t rd_sel;

    // ------------------------------
    // Arbitration
    // ------------------------------
    assign o_wr_gnt = rr_pick(i_wr_req, wr_last);
    assign o_rd_gnt = rr_pick(i_rd_req, rd_last);
    assign wr_sel   = oh_to_port(o_wr_gnt);
    assign rd_sel   = oh_to_port(o_rd_gnt);

    always_ff @(posedge i_core_clk) begin
        if (i_rst) begin
            wr_last    <= '0;
            rd_last    <= '0;
            o_rd_valid <= '0;
        end else begin
            if (|o_wr_gnt) begin
                wr_last <= wr_sel;
            end
            if (|o_rd_gnt) begin
                rd_last <= rd_sel;
            end
            // Owner flag returns together with the read data
            o_rd_valid <= o_rd_gnt;
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge i_core_clk) begin
        if (|o_wr_gnt) begin
            ram[i_wr[wr_sel].addr] <= i_wr[wr_sel].data;
        end
    end

    // Read data registers every cycle and only granted reads are flagged valid
    always_ff @(posedge i_core_clk) begin
        o_rd_data <= ram[i_rd_addr[rd_sel]];
    end

endmodule

`default_nettype wire

//--- src/egress_port_q.sv
// Egress port queue
// Writer stores incoming packets into one spare buffer and queues a
// descriptor, reader replays the packet from memory through a two-entry
// output buffer. With enable low the input bypasses through one register.
`timescale 1ns/1ns
`default_nettype none

module egress_port_q (
    input  logic                   i_core_clk,
    input  logic                   i_rst,
    input  logic                   i_enable,
    input  logic                   i_init_done,
    input  logic                   i_in_valid,
    input  egress_pkg::beat_t      i_in_beat,
    output logic                   o_in_ready,
    output logic                   o_out_valid,
    output egress_pkg::beat_t      o_out_beat,
    input  logic                   i_out_ready,
    output logic                   o_alloc_req,
    input  logic                   i_alloc_gnt,
    input  egress_pkg::buf_ptr_t   i_alloc_ptr,
    output logic                   o_rel_valid,
    output egress_pkg::buf_ptr_t   o_rel_ptr,
    output logic                   o_wr_req,
    output egress_pkg::mem_wr_t    o_wr,
    input  logic                   i_wr_gnt,
    output logic                   o_rd_req,
    output egress_pkg::mem_addr_t  o_rd_addr,
    input  logic                   i_rd_gnt,
    input  logic                   i_rd_valid,
    input  egress_pkg::data_t      i_rd_data
);
    import egress_pkg::*;

    typedef enum logic {IDLE, READ} rd_state_t;

    // Writer
    logic                  spare_vld;
    buf_ptr_t              spare_ptr;
    beat_idx_t             wr_idx;
    // Descriptor FIFO
    desc_t                 desc_mem [DESC_DEPTH];
    logic [DESC_PTR_WID-1:0] desc_wr;
    logic [DESC_PTR_WID-1:0] desc_rd;
    logic [DESC_PTR_WID:0] desc_cnt;
    logic                  desc_push;
    logic                  desc_pop;
    logic                  desc_space;
    // Reader
    rd_state_t             state;
    desc_t                 cur_desc;
    beat_idx_t             rd_idx;
    logic                  rd_final;
    logic                  meta_last;
    port_t                 meta_dest;
    logic [1:0]            credit;
    logic                  credit_ok;
    // Output buffer
    beat_t                 obuf [2];
    logic                  obuf_wr;
    logic                  obuf_rd;
    logic [1:0]            obuf_cnt;
    logic                  obuf_pop;
    beat_t                 rd_beat;
    // Bypass
    logic                  byp_load;
    logic                  byp_vld;
    beat_t                 byp_beat;

    // ------------------------------
    // Writer
    // ------------------------------
    assign o_alloc_req = i_init_done && !spare_vld;
    assign desc_space  = int'(desc_cnt) < DESC_DEPTH;
    assign o_wr_req    = i_enable && i_in_valid && spare_vld && desc_space;
    assign o_wr.addr   = '{ptr: spare_ptr, idx: wr_idx};
    assign o_wr.data   = i_in_beat.data;
    assign desc_push   = i_wr_gnt && i_in_beat.last;

    always_ff @(posedge i_core_clk) begin
        if (i_rst) begin
            spare_vld <= 1'b0;
            wr_idx    <= '0;
        end else if (i_wr_gnt) begin
            wr_idx <= i_in_beat.last ? '0 : wr_idx + 1'b1;
            if (i_in_beat.last) begin
                spare_vld <= 1'b0;
            end
        end else if (i_alloc_gnt) begin
            spare_vld <= 1'b1;
        end
    end

    always_ff @(posedge i_core_clk) begin
        if (i_alloc_gnt) begin
            spare_ptr <= i_alloc_ptr;
        end
        if (desc_push) begin
            desc_mem[desc_wr] <= '{ptr: spare_ptr, len: {1'b0, wr_idx} + 1'b1,
                                   dest: i_in_beat.dest};
        end
    end

    // ------------------------------
    // Descriptor FIFO
    // ------------------------------
    assign desc_pop = (state == IDLE) && i_enable && (desc_cnt != '0);

    always_ff @(posedge i_core_clk) begin
        if (i_rst) begin
            desc_wr  <= '0;
            desc_rd  <= '0;
            desc_cnt <= '0;
        end else begin
            if (desc_push) begin
                desc_wr <= desc_wr + 1'b1;
            end
            if (desc_pop) begin
                desc_rd <= desc_rd + 1'b1;
            end
            if (desc_push && !desc_pop) begin
                desc_cnt <= desc_cnt + 1'b1;
            end else if (!desc_push && desc_pop) begin
                desc_cnt <= desc_cnt - 1'b1;
            end
        end
    end

    // ------------------------------
    // Reader
    // ------------------------------
    // Credit counts buffered beats plus the read in flight
    assign credit_ok = (credit != 2'd2) || obuf_pop;
    assign o_rd_req  = (state == READ) && credit_ok;
    assign o_rd_addr = '{ptr: cur_desc.ptr, idx: rd_idx};
    assign rd_final  = ({1'b0, rd_idx} + 1'b1) == cur_desc.len;

    always_ff @(posedge i_core_clk) begin
        if (i_rst) begin
            state       <= IDLE;
            rd_idx      <= '0;
            o_rel_valid <= 1'b0;
            credit      <= '0;
        end else begin
            o_rel_valid <= 1'b0;
            if (i_rd_gnt && !obuf_pop) begin
                credit <= credit + 1'b1;
            end else if (!i_rd_gnt && obuf_pop) begin
                credit <= credit - 1'b1;
            end
            case (state)
                IDLE: begin
                    if (desc_pop) begin
                        state  <= READ;
                        rd_idx <= '0;
                    end
                end
                READ: begin
                    if (i_rd_gnt) begin
                        rd_idx <= rd_idx + 1'b1;
                        if (rd_final) begin
                            state       <= IDLE;
                            o_rel_valid <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Beat flags ride alongside the single read in flight
    always_ff @(posedge i_core_clk) begin
        if (desc_pop) begin
            cur_desc <= desc_mem[desc_rd];
        end
        if (i_rd_gnt) begin
            meta_last <= rd_final;
            meta_dest <= cur_desc.dest;
            o_rel_ptr <= cur_desc.ptr;
        end
    end

    // ------------------------------
    // Output buffer and bypass
    // ------------------------------
    assign rd_beat  = '{data: i_rd_data, last: meta_last, dest: meta_dest};
    assign obuf_pop = i_enable && (obuf_cnt != '0) && i_out_ready;
    assign byp_load = !i_enable && i_init_done && (!byp_vld || i_out_ready);

    assign o_in_ready  = i_enable ? i_wr_gnt : byp_load;
    assign o_out_valid = i_enable ? (obuf_cnt != '0) : byp_vld;
    assign o_out_beat  = i_enable ? obuf[obuf_rd] : byp_beat;

    always_ff @(posedge i_core_clk) begin
        if (i_rst) begin
            obuf_wr  <= 1'b0;
            obuf_rd  <= 1'b0;
            obuf_cnt <= '0;
            byp_vld  <= 1'b0;
        end else begin
            if (i_rd_valid) begin
                obuf_wr <= !obuf_wr;
            end
            if (obuf_pop) begin
                obuf_rd <= !obuf_rd;
            end
            if (i_rd_valid && !obuf_pop) begin
                obuf_cnt <= obuf_cnt + 1'b1;
            end else if (!i_rd_valid && obuf_pop) begin
                obuf_cnt <= obuf_cnt - 1'b1;
            end
            if (byp_load) begin
                byp_vld <= i_in_valid;
            end
        end
    end

    always_ff @(posedge i_core_clk) begin
        if (i_rd_valid) begin
            obuf[obuf_wr] <= rd_beat;
        end
        if (byp_load) begin
            byp_beat <= i_in_beat;
        end
    end

endmodule

`default_nettype wire

//--- src/egress_qs.sv
// Egress queueing top level
// Packets are buffered in a shared on-chip memory and sent out on the
// port they arrived on. Enable low bypasses the queues.
`timescale 1ns/1ns
`default_nettype none

module egress_qs (
    input  logic                                i_core_clk,
    input  logic                                i_rst,
    input  logic                                i_enable,
    input  logic [egress_pkg::NUM_PORTS-1:0]    i_in_valid,
    input  egress_pkg::beat_t                   i_in_beat [egress_pkg::NUM_PORTS],
    output logic [egress_pkg::NUM_PORTS-1:0]    o_in_ready,
    output logic [egress_pkg::NUM_PORTS-1:0]    o_out_valid,
    output egress_pkg::beat_t                   o_out_beat [egress_pkg::NUM_PORTS],
    input  logic [egress_pkg::NUM_PORTS-1:0]    i_out_ready,
    output logic                                o_init_done
);
    import egress_pkg::*;

    logic [NUM_PORTS-1:0] alloc_req;
    logic [NUM_PORTS-1:0] alloc_gnt;
    buf_ptr_t             alloc_ptr;
    logic [NUM_PORTS-1:0] rel_valid;
    buf_ptr_t             rel_ptr [NUM_PORTS];
    logic [NUM_PORTS-1:0] wr_req;
    logic [NUM_PORTS-1:0] wr_gnt;
    mem_wr_t              wr [NUM_PORTS];
    logic [NUM_PORTS-1:0] rd_req;
    logic [NUM_PORTS-1:0] rd_gnt;
    logic [NUM_PORTS-1:0] rd_valid;
    mem_addr_t            rd_addr [NUM_PORTS];
    data_t                rd_data;

    egress_free_list i_egress_free_list (
        .i_core_clk  ( i_core_clk ),
        .i_rst       ( i_rst ),
        .i_alloc_req ( alloc_req ),
        .o_alloc_gnt ( alloc_gnt ),
        .o_alloc_ptr ( alloc_ptr ),
        .i_rel_valid ( rel_valid ),
        .i_rel_ptr   ( rel_ptr ),
        .o_init_done ( o_init_done )
    );

    // Each port replays its packets on the port where they arrived
    generate
        for (genvar g_port = 0; g_port < NUM_PORTS; g_port++) begin : g__port
            egress_port_q i_egress_port_q (
                .i_core_clk  ( i_core_clk ),
                .i_rst       ( i_rst ),
                .i_enable    ( i_enable ),
                .i_init_done ( o_init_done ),
                .i_in_valid  ( i_in_valid[g_port] ),
                .i_in_beat   ( i_in_beat[g_port] ),
                .o_in_ready  ( o_in_ready[g_port] ),
                .o_out_valid ( o_out_valid[g_port] ),
                .o_out_beat  ( o_out_beat[g_port] ),
                .i_out_ready ( i_out_ready[g_port] ),
                .o_alloc_req ( alloc_req[g_port] ),
                .i_alloc_gnt ( alloc_gnt[g_port] ),
                .i_alloc_ptr ( alloc_ptr ),
                .o_rel_valid ( rel_valid[g_port] ),
                .o_rel_ptr   ( rel_ptr[g_port] ),
                .o_wr_req    ( wr_req[g_port] ),
                .o_wr        ( wr[g_port] ),
                .i_wr_gnt    ( wr_gnt[g_port] ),
                .o_rd_req    ( rd_req[g_port] ),
                .o_rd_addr   ( rd_addr[g_port] ),
                .i_rd_gnt    ( rd_gnt[g_port] ),
                .i_rd_valid  ( rd_valid[g_port] ),
                .i_rd_data   ( rd_data )
            );
        end : g__port
    endgenerate

    egress_pkt_mem i_egress_pkt_mem (
        .i_core_clk ( i_core_clk ),
        .i_rst      ( i_rst ),
        .i_wr_req   ( wr_req ),
        .i_wr       ( wr ),
        .o_wr_gnt   ( wr_gnt ),
        .i_rd_req   ( rd_req ),
        .i_rd_addr  ( rd_addr ),
        .o_rd_gnt   ( rd_gnt ),
        .o_rd_valid ( rd_valid ),
        .o_rd_data  ( rd_data )
    );

endmodule

`default_nettype wire

//--- bench/egress_tb_clk.sv
// Testbench clock generator
// Free-running clock with a 4 ns period
`timescale 1ns/1ns
`default_nettype none

module egress_tb_clk (
    output logic o_clk
);
    localparam int HALF_PERIOD = 2;

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #HALF_PERIOD;
        o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

//--- bench/egress_tb.sv
// Egress queueing testbench
// Random packets per port are checked against a queue of expected beats
// per port. Covers initialisation, queued ordering, random back-pressure,
// buffer exhaustion and the bypass path.
`timescale 1ns/1ns
`default_nettype none

module egress_tb;
    import egress_pkg::*;

    // About 244 packets of up to 8 beats with generous room for stalls
    localparam int MAX_CYCLES   = 20000;
    localparam int INIT_LIMIT   = 20;
    localparam int QUIET_CYCLES = 50;

    logic                 clk;
    logic                 rst;
    logic                 enable;
    logic [NUM_PORTS-1:0] in_valid;
    beat_t                in_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_ready;
    logic [NUM_PORTS-1:0] out_valid;
    beat_t                out_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_ready;
    logic                 init_done;

    // Model state
    beat_t                tx_q  [NUM_PORTS][$];
    beat_t                exp_q [NUM_PORTS][$];
    logic [NUM_PORTS-1:0] presenting;
    logic [NUM_PORTS-1:0] byp_due;
    int                   seed;
    int                   cycle_cnt;
    int                   in_quiet;
    int                   ready_mode;
    logic                 gaps;
    logic                 bypass;
    logic                 hold_reset;
    logic                 init_seen;
    string                test_name;

    egress_tb_clk i_egress_tb_clk (
        .o_clk ( clk )
    );

    egress_qs uut (
        .i_core_clk  ( clk ),
        .i_rst       ( rst ),
        .i_enable    ( enable ),
        .i_in_valid  ( in_valid ),
        .i_in_beat   ( in_beat ),
        .o_in_ready  ( in_ready ),
        .o_out_valid ( out_valid ),
        .o_out_beat  ( out_beat ),
        .i_out_ready ( out_ready ),
        .o_init_done ( init_done )
    );

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_beat(input string name, input beat_t exp, input beat_t act);
        if (act !== exp) begin
            $display("ERR %s expected data=%h last=%b dest=%h actual data=%h last=%b dest=%h",
                     name, exp.data, exp.last, exp.dest, act.data, act.last, act.dest);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // ------------------------------
    // Stimulus and model
    // ------------------------------
    // Packet of 1 to BUFFER_BEATS beats with dest set to its entry port
    task automatic add_packet(input int p);
        int    len;
        beat_t b;
        len = 1 + int'($unsigned($random(seed)) % BUFFER_BEATS);
        for (int i = 0; i < len; i++) begin
            b.data = {$random(seed), $random(seed)};
            b.last = (i == len - 1);
            b.dest = port_t'(p);
            tx_q[p].push_back(b);
            exp_q[p].push_back(b);
        end
    endtask

    function automatic int pending_beats();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n = n + tx_q[p].size() + exp_q[p].size();
        end
        return n;
    endfunction

    task automatic drive_inputs();
        rst    = hold_reset;
        enable = !bypass;
        for (int p = 0; p < NUM_PORTS; p++) begin
            // A presented beat holds until it transfers
            if (!presenting[p] && tx_q[p].size() > 0) begin
                presenting[p] = !gaps || (($random(seed) & 3) != 0);
            end
            in_valid[p] = presenting[p];
            if (presenting[p]) begin
                in_beat[p] = tx_q[p][0];
            end else begin
                in_beat[p] = '0;
            end
            case (ready_mode)
                0: out_ready[p] = 1'b1;
                1: out_ready[p] = (($random(seed) & 1) != 0);
                default: out_ready[p] = 1'b0;
            endcase
        end
    endtask

    task automatic sample_outputs();
        int moved;
        string name;
        moved = 0;
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d beats still outstanding",
                     cycle_cnt, pending_beats());
            stop_run();
        end
        if (rst) begin
            check_flag({test_name, " init_done"}, 1'b0, init_done);
            for (int p = 0; p < NUM_PORTS; p++) begin
                name = $sformatf("%s port %0d", test_name, p);
                check_flag({name, " in_ready"}, 1'b0, in_ready[p]);
                check_flag({name, " out_valid"}, 1'b0, out_valid[p]);
            end
        end else begin
            if (init_seen) begin
                check_flag({test_name, " init_done stays high"}, 1'b1, init_done);
            end
            init_seen = init_seen || init_done;
            for (int p = 0; p < NUM_PORTS; p++) begin
                name = $sformatf("%s port %0d", test_name, p);
                if (!init_done) begin
                    check_flag({name, " in_ready before init"}, 1'b0, in_ready[p]);
                end
                // Bypass beat must show one cycle after its transfer
                if (byp_due[p] && out_ready[p]) begin
                    check_flag({name, " bypass latency"}, 1'b1, out_valid[p]);
                end
                byp_due[p] = 1'b0;
                if (out_valid[p] && out_ready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        $display("Port %0d sent a beat that no packet accounts for", p);
                        stop_run();
                    end else begin
                        check_beat(name, exp_q[p].pop_front(), out_beat[p]);
                    end
                end
                if (in_valid[p] && in_ready[p]) begin
                    void'(tx_q[p].pop_front());
                    presenting[p] = 1'b0;
                    byp_due[p]    = !enable;
                    moved++;
                end
            end
            in_quiet = (moved != 0) ? 0 : in_quiet + 1;
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        drive_inputs();
        @(posedge clk);
        sample_outputs();
    endtask

    task automatic wait_init();
        int n;
        n = 0;
        while (!init_seen) begin
            if (n == INIT_LIMIT) begin
                $display("init_done did not rise within %0d cycles of reset", INIT_LIMIT);
                stop_run();
            end
            run_cycle();
            n++;
        end
    endtask

    task automatic wait_drain();
        while (pending_beats() != 0) begin
            run_cycle();
        end
        // Idle cycles catch any extra beat
        repeat (8) run_cycle();
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        seed       = 28483;
        cycle_cnt  = 0;
        in_quiet   = 0;
        ready_mode = 0;
        gaps       = 1'b0;
        bypass     = 1'b0;
        hold_reset = 1'b1;
        init_seen  = 1'b0;
        presenting = '0;
        byp_due    = '0;
        rst        = 1'b1;
        enable     = 1'b1;
        in_valid   = '0;
        out_ready  = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_beat[p] = '0;
        end

        // Port 0 packets are offered from reset on, through the free list fill
        for (int i = 0; i < 40; i++) begin
            add_packet(0);
        end

        test_name = "reset";
        repeat (10) run_cycle();
        hold_reset = 1'b0;

        test_name = "init";
        wait_init();

        test_name = "queued_order";
        wait_drain();

        test_name  = "concurrent_backpressure";
        ready_mode = 1;
        gaps       = 1'b1;
        for (int i = 0; i < 60; i++) begin
            add_packet(0);
            add_packet(1);
        end
        wait_drain();

        // Output held off until the input side runs out of buffers
        test_name  = "buffer_exhaustion";
        ready_mode = 2;
        gaps       = 1'b0;
        for (int i = 0; i < 12; i++) begin
            add_packet(0);
            add_packet(1);
        end
        in_quiet = 0;
        while (in_quiet < QUIET_CYCLES) begin
            run_cycle();
        end
        if (tx_q[0].size() + tx_q[1].size() == 0) begin
            $display("Input ready never stalled with 24 packets and output held off");
            stop_run();
        end
        ready_mode = 0;
        wait_drain();

        test_name = "bypass";
        bypass    = 1'b1;
        gaps      = 1'b1;
        for (int i = 0; i < 30; i++) begin
            add_packet(0);
            add_packet(1);
        end
        wait_drain();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
src/egress_pkg.sv
src/egress_free_list.sv
src/egress_pkt_mem.sv
src/egress_port_q.sv
src/egress_qs.sv
bench/egress_tb_clk.sv
bench/egress_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the egress queueing testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module egress_tb \
    -f files.f -o egress_tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/egress_tb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "TEST RESULT: FAIL" "$SIM_LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$SIM_LOG"; then
    echo "No result line found in $SIM_LOG"
    exit 1
fi
exit 0
